//--- bench/rv_core_cases.hex
// 14 program words from address 0, then expected store address, expected store data
// unused program words are jal x0,0; data memory word 0 seeded as 62084190
// add: 100 + -7
06400093 ff900113 002081b3 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 0000005d
// sub: -7 - 100
06400093 ff900113 401101b3 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 ffffff95
// addi with negative immediate: 100 + -300
06400093 ed408193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 ffffff38
// slt: -7 < 100 is true
06400093 ff900113 001121b3 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000001
// slt: 100 < -7 is false, overwrites 55
06400093 ff900113 03700193 0020a1b3 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000000
// slti: -7 < -5 is true
ff900113 ffb12193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000001
// lui with upper bit set
abcde1b7 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 abcde000
// auipc at pc 8
00000013 00000013 00001197 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00001008
// lw word 0, add 5, store at 32 + 36
00002083 00508193 02000213 02322223 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000044 62084195
// beq taken, 5 == 5
00500093 00500113 00208663 01100193 04302023 02200193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000022
// beq not taken, 5 != 6
00500093 00600113 00208663 01100193 04302023 02200193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000011
// bne taken, 5 != 6
00500093 00600113 00209663 01100193 04302023 02200193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000022
// bne not taken, 5 == 5
00500093 00500113 00209663 01100193 04302023 02200193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000011
// jal x3 from pc 4 to pc 16, link 8 plus target marker 200
00000013 00c001ef 10018193 04302023 20018193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000208
// jalr x3 to 17 + 4 with bit 0 cleared, link 8 plus marker 200
01100093 004081e7 10018193 04302023 30018193 20018193 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000208
// unknown opcode and calc with funct7 01 leave x3 at 77
07700193 001081fb 022081b3 04302023 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 0000006f 00000040 00000077

//--- src.f
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
bench/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module rv_core_tb \
    --Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/rv_core_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only when the testbench printed its pass line
if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

    ////////////////////////////////////////////////////////////
    // run limits and case table
    ////////////////////////////////////////////////////////////

    localparam int n_cases      = 16;
    localparam int case_words   = 16;
    localparam int prog_words   = 14;
    localparam int reset_cycles = 16;
    localparam int store_window = 64;
    // reset plus the store window, per case
    localparam int max_cycles   = n_cases * (reset_cycles + store_window);

    localparam logic [xlen-1:0] self_loop = 32'h0000006f;  // jal x0,0
    localparam logic [31:0]     seed      = 32'hde77;

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_data;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic            dmem_we;
    logic [xlen-1:0] dmem_rdata;

    // flat table, 16 words per case
    logic [xlen-1:0] cases [0:n_cases*case_words-1];

    // memory models
    logic [xlen-1:0] imem [0:15];
    logic [xlen-1:0] dmem [0:63];

    int pass_count;
    int fail_count;
    int cycle_count;
    bit case_ok;

    ////////////////////////////////////////////////////////////
    // clock and DUT
    ////////////////////////////////////////////////////////////

    always #50 clk = ~clk;

    rv_core rv_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // both memories read combinationally, word addressed
    // a misaligned fetch reads a self loop, the core then parks there
    assign imem_data  = (imem_addr[1:0] == 2'b00) ? imem[imem_addr[5:2]] : self_loop;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic compare_word(input string name, input string what,
                                input logic [xlen-1:0] expected,
                                input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s expected %08h actual %08h",
                     name, what, expected, actual);
            case_ok = 1'b0;
        end
    endtask

    // program words from the table, rest is a self loop
    task automatic load_memories(input int idx);
        logic [31:0] state;
        for (int i = 0; i < 16; i++) begin
            if (i < prog_words) begin
                imem[i] = cases[idx*case_words + i];
            end else begin
                imem[i] = self_loop;
            end
        end
        // sequence continues across the whole array
        state = seed;
        for (int i = 0; i < 64; i++) begin
            state   = xorshift32(state);
            dmem[i] = state;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one case: reset, run, catch the first store
    ////////////////////////////////////////////////////////////

    task automatic run_case(input int idx);
        string           name;
        bit              seen;
        logic [xlen-1:0] got_addr;
        logic [xlen-1:0] got_data;
        logic [xlen-1:0] exp_addr;
        logic [xlen-1:0] exp_data;
        name     = $sformatf("case_%0d", idx);
        exp_addr = cases[idx*case_words + prog_words];
        exp_data = cases[idx*case_words + prog_words + 1];
        seen     = 1'b0;
        got_addr = '0;
        got_data = '0;
        case_ok  = 1'b1;

        @(posedge clk);
        #1 arst_n = 1'b0;
        load_memories(idx);
        repeat (reset_cycles) @(posedge clk);
        #1 arst_n = 1'b1;

        // sample in the middle of the cycle, values settled
        for (int k = 0; k < store_window && !seen; k++) begin
            @(negedge clk);
            if (dmem_we) begin
                seen     = 1'b1;
                got_addr = dmem_addr;
                got_data = dmem_wdata;
            end
        end

        if (seen) begin
            // store commits at this edge
            @(posedge clk);
            dmem[got_addr[7:2]] = got_data;
            compare_word(name, "addr", exp_addr, got_addr);
            compare_word(name, "data", exp_data, got_data);
        end else begin
            $display("%s: no store seen within %0d cycles", name, store_window);
            case_ok = 1'b0;
        end

        if (case_ok) begin
            pass_count++;
            $display("%s pass", name);
        end else begin
            fail_count++;
            $display("%s fail", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // timeout
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("run stopped after %0d cycles without finishing all cases", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // main
    ////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        $readmemh("bench/rv_core_cases.hex", cases);

        for (int c = 0; c < n_cases; c++) begin
            run_case(c);
        end

        $display("cases passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_cases) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    // instruction port
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    // data port
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_we,
    input  logic [xlen-1:0] dmem_rdata
);

    logic [xlen-1:0]       pc;
    logic                  run;

    ctrl_t                 ctrl;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rdata0;
    logic [xlen-1:0]       rdata1;
    exec_res_t             res;
    logic [xlen-1:0]       wb_data;
    logic                  wb_en;
    logic [xlen-1:0]       next_pc;

    ////////////////////////////////////////////////////////////
    // pc and run flag
    ////////////////////////////////////////////////////////////

    // run goes high one edge after reset release, pc holds until then
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
            pc  <= '0;
        end else begin
            run <= 1'b1;
            if (run) begin
                pc <= next_pc;
            end
        end
    end

    assign imem_addr = pc;

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    rv_decode rv_decode_inst (
        .instr (imem_data),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    // writes gated until the first instruction is really fetched
    rv_regfile rv_regfile_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wb_data),
        .we     (wb_en & run),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    rv_execute rv_execute_inst (
        .ctrl   (ctrl),
        .rdata0 (rdata0),
        .rdata1 (rdata1),
        .imm    (imm),
        .res    (res)
    );

    rv_result rv_result_inst (
        .ctrl       (ctrl),
        .res        (res),
        .pc         (pc),
        .imm        (imm),
        .dmem_rdata (dmem_rdata),
        .wb_data    (wb_data),
        .wb_en      (wb_en),
        .next_pc    (next_pc)
    );

    // memory address from the alu, store data straight from rs2
    assign dmem_addr  = res.alu_res;
    assign dmem_wdata = rdata1;
    assign dmem_we    = ctrl.mem_write & run;

endmodule

//--- source/rv_result.sv
`timescale 1ns/1ps

module rv_result import rv_pkg::*; (
    input  ctrl_t           ctrl,
    input  exec_res_t       res,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] dmem_rdata,
    output logic [xlen-1:0] wb_data,
    output logic            wb_en,
    output logic [xlen-1:0] next_pc
);

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_plus_imm;

    // both adders shared by writeback and next pc
    assign pc_plus4    = pc + pc_step;
    assign pc_plus_imm = pc + imm;

    ////////////////////////////////////////////////////////////
    // writeback
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.wb_sel)
            wb_alu:   wb_data = res.alu_res;
            wb_mem:   wb_data = dmem_rdata;
            // link address for jal and jalr
            wb_pc4:   wb_data = pc_plus4;
            wb_pcimm: wb_data = pc_plus_imm;
            default:  wb_data = res.alu_res;
        endcase
    end

    assign wb_en = ctrl.reg_write;

    ////////////////////////////////////////////////////////////
    // next pc
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.pc_sel)
            pc_seq:    next_pc = pc_plus4;
            // not taken falls through
            pc_branch: next_pc = res.branch_taken ? pc_plus_imm : pc_plus4;
            pc_jal:    next_pc = pc_plus_imm;
            // jalr target has its lsb cleared
            pc_jalr:   next_pc = {res.alu_res[xlen-1:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

endmodule

//--- source/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] rdata0,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] imm,
    output exec_res_t       res
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic            rs_equal;

    ////////////////////////////////////////////////////////////
    // operand select
    ////////////////////////////////////////////////////////////

    // zero on port a gives lui its plain immediate
    assign op_a = ctrl.alu_src0 ? '0 : rdata0;
    // immediate forms vs register forms
    assign op_b = ctrl.alu_src1 ? imm : rdata1;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_res = op_a + op_b;
            alu_sub: alu_res = op_a - op_b;
            // result is 0 or 1
            alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch decision
    ////////////////////////////////////////////////////////////

    // compare the raw register values, not the alu operands
    assign rs_equal = (rdata0 == rdata1);

    always_comb begin
        res.alu_res = alu_res;
        // beq wants equal, bne wants not equal
        res.branch_taken = (ctrl.pc_sel == pc_branch) && (rs_equal != ctrl.branch_ne);
    end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [xlen-1:0]       wdata,
    input  logic                  we,
    output logic [xlen-1:0]       rdata0,
    output logic [xlen-1:0]       rdata1
);

    // x1..x31, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            // writes to x0 dropped
            regs[rd] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // combinational, no bypass needed in a single-cycle core
    always_comb begin
        rdata0 = (rs1 == '0) ? '0 : regs[rs1];
        rdata1 = (rs2 == '0) ? '0 : regs[rs2];
    end

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic [xlen-1:0]       instr,
    output ctrl_t                 ctrl,
    output logic [xlen-1:0]       imm,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd
);

    ////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register indices sit at fixed positions in every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    ////////////////////////////////////////////////////////////
    // immediate formats
    ////////////////////////////////////////////////////////////

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // sign bit is always instr[31]
    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    // branch and jump offsets are even, lsb forced to zero
    assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(xlen-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    // format picked by opcode
    always_comb begin
        case (opcode)
            op_jalr,
            op_load,
            op_calci:  imm = imm_i;
            op_store:  imm = imm_s;
            op_branch: imm = imm_b;
            op_lui,
            op_auipc:  imm = imm_u;
            op_jal:    imm = imm_j;
            default:   imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        // unknown patterns fall through as all zero
        ctrl = '0;
        case (opcode)
            op_lui: begin
                // zero + imm
                ctrl.alu_src0  = 1'b1;
                ctrl.alu_src1  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_auipc: begin
                ctrl.wb_sel    = wb_pcimm;
                ctrl.reg_write = 1'b1;
            end
            op_jal: begin
                ctrl.wb_sel    = wb_pc4;
                ctrl.pc_sel    = pc_jal;
                ctrl.reg_write = 1'b1;
            end
            op_jalr: begin
                // target is rs1 + imm through the alu
                ctrl.wb_sel    = wb_pc4;
                ctrl.pc_sel    = pc_jalr;
                ctrl.alu_src1  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_branch: begin
                if (funct3 == f3_beq || funct3 == f3_bne) begin
                    ctrl.pc_sel    = pc_branch;
                    ctrl.branch_ne = (funct3 == f3_bne);
                end
            end
            op_load: begin
                // word access only, address = rs1 + imm
                ctrl.wb_sel    = wb_mem;
                ctrl.alu_src1  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src1  = 1'b1;
            end
            op_calci: begin
                if (funct3 == f3_addsub || funct3 == f3_slt) begin
                    ctrl.alu_op    = (funct3 == f3_slt) ? alu_slt : alu_add;
                    ctrl.alu_src1  = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            op_calc: begin
                // funct7 must match too, so mul/div encodings stay no-ops
                if (funct3 == f3_slt && funct7 == f7_add) begin
                    ctrl.alu_op    = alu_slt;
                    ctrl.reg_write = 1'b1;
                end else if (funct3 == f3_addsub && funct7 == f7_add) begin
                    ctrl.alu_op    = alu_add;
                    ctrl.reg_write = 1'b1;
                end else if (funct3 == f3_addsub && funct7 == f7_sub) begin
                    ctrl.alu_op    = alu_sub;
                    ctrl.reg_write = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // data and address width
    localparam int xlen       = 32;
    // register index width, 32 architectural registers
    localparam int reg_addr_w = 5;

    // sequential pc increment, one word per instruction
    localparam logic [xlen-1:0] pc_step = xlen'(4);

    ////////////////////////////////////////////////////////////
    // rv32i encodings
    ////////////////////////////////////////////////////////////

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_calci  = 7'b0010011;
    localparam logic [6:0] op_calc   = 7'b0110011;

    // funct3, instr[14:12]
    localparam logic [2:0] f3_addsub = 3'b000;
    localparam logic [2:0] f3_slt    = 3'b010;
    localparam logic [2:0] f3_beq    = 3'b000;
    localparam logic [2:0] f3_bne    = 3'b001;

    // funct7, instr[31:25]
    localparam logic [6:0] f7_add = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // control fields
    ////////////////////////////////////////////////////////////

    // writeback source
    typedef enum logic [1:0] {
        wb_alu   = 2'b00,   // alu result
        wb_mem   = 2'b01,   // loaded word
        wb_pc4   = 2'b10,   // link value
        wb_pcimm = 2'b11    // auipc
    } wb_sel_e;

    // next pc source
    typedef enum logic [1:0] {
        pc_seq    = 2'b00,  // pc + 4
        pc_branch = 2'b01,  // pc + imm when taken
        pc_jal    = 2'b10,  // pc + imm always
        pc_jalr   = 2'b11   // alu result, bit 0 cleared
    } pc_sel_e;

    // alu operation
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_sub = 2'b01,
        alu_slt = 2'b10,    // signed compare
        alu_nop = 2'b11     // spare code, gives zero
    } alu_op_e;

    // decoded control word, all zero is a no-op
    typedef struct packed {
        wb_sel_e wb_sel;
        logic    mem_write;
        pc_sel_e pc_sel;
        alu_op_e alu_op;
        logic    alu_src0;  // 1 -> zero instead of rs1
        logic    alu_src1;  // 1 -> imm instead of rs2
        logic    reg_write;
        logic    branch_ne; // 1 -> bne, 0 -> beq
    } ctrl_t;

    // execute to result stage
    typedef struct packed {
        logic [xlen-1:0] alu_res;
        logic            branch_taken;
    } exec_res_t;

endpackage
